// File: src.f
hdl/ram_writer_pkg.sv
hdl/stream_fifo.sv
hdl/write_address_counter.sv
hdl/block_write_fsm.sv
hdl/stream_ram_writer.sv
tb/wb_ram_model.sv
tb/tb_stream_ram_writer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result is taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_stream_ram_writer -f src.f -o sim_tb > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator returned an error" >> sim.log
cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "Result: fail"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Result: no pass message"; exit 1; }
echo "Result: pass"

// File: tb/tb_stream_ram_writer.sv
`timescale 1ns/1ps

module tb_stream_ram_writer;
  import ram_writer_pkg::*;

  localparam int DATA_WIDTH  = 32;
  localparam int FIFO_DEPTH  = 64;
  localparam int TOTAL_WORDS = 16 + 80 + 96;
  localparam wb_addr_t BASE  = 32'h0001_0000;

  logic                  aclk;
  logic                  aresetn;
  logic [DATA_WIDTH-1:0] s_tdata;
  logic                  s_tvalid;
  logic                  s_tready;
  wb_addr_t              base_addr;
  block_idx_t            last_block;
  block_idx_t            sts_block;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  wb_addr_t              wb_adr;
  logic [DATA_WIDTH-1:0] wb_dat_o;
  logic                  wb_ack;
  logic                  slow;
  logic                  log_valid;
  logic [31:0]           log_addr;
  logic [DATA_WIDTH-1:0] log_data;

  logic [DATA_WIDTH-1:0] exp_q[$];   // Accepted words not yet written
  int                    blk_seq[$]; // Block index of each finished block
  int    m_beat;
  int    m_block;
  int    n_sent;
  int    n_written;
  int    errors;
  int    test_errors;
  int    tests_run;
  int    tests_failed;
  bit    cyc_seen;
  bit    bp_seen;
  string cur_test;

  stream_ram_writer #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_stream_ram_writer (
    .aclk(aclk), .aresetn(aresetn),
    .s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready),
    .base_addr(base_addr), .last_block(last_block), .sts_block(sts_block),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
  );

  wb_ram_model #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_wb_ram_model (
    .aclk(aclk), .aresetn(aresetn), .slow(slow),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat(wb_dat_o), .wb_ack(wb_ack),
    .log_valid(log_valid), .log_addr(log_addr), .log_data(log_data)
  );

  initial
  begin
    aclk = 1'b0;
    forever
    begin
      #4 aclk = ~aclk;
    end
  end

  // Watchdog, 40 cycles per word plus a margin
  initial
  begin
    #((TOTAL_WORDS * 40 + 2000) * 8);
    $display("Timeout: the run did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  // Reference model of the write side, checked against every logged write
  always @(posedge aclk)
  begin
    if (wb_cyc)
    begin
      cyc_seen = 1'b1;
    end
    if (aresetn && wb_stb)
    begin
      assert (wb_cyc && wb_we)
      else
      begin
        $display("** Error %s strobe: expected cyc/we 1/1, actual %b/%b", cur_test, wb_cyc,
                 wb_we);
        errors++;
      end
    end
    if (aresetn && log_valid)
    begin
      logic [DATA_WIDTH-1:0] exp_data;
      wb_addr_t              exp_addr;
      exp_addr = BASE + wb_addr_t'((m_block * BLOCK_BEATS + m_beat) * (DATA_WIDTH / 8));
      exp_data = '0;
      assert (exp_q.size() > 0)
      else
      begin
        $display("** Error %s: write with no accepted word left", cur_test);
        errors++;
      end
      if (exp_q.size() > 0)
      begin
        exp_data = exp_q.pop_front();
      end
      assert (log_data == exp_data)
      else
      begin
        $display("** Error %s data: expected %h, actual %h", cur_test, exp_data, log_data);
        errors++;
      end
      assert (log_addr == exp_addr)
      else
      begin
        $display("** Error %s address: expected %h, actual %h", cur_test, exp_addr, log_addr);
        errors++;
      end
      n_written++;
      if (m_beat == BLOCK_BEATS - 1)
      begin
        // Block index as seen on the bus
        blk_seq.push_back(int'((log_addr - BASE) / (BLOCK_BEATS * (DATA_WIDTH / 8))));
        m_beat  = 0;
        m_block = (m_block < int'(last_block)) ? m_block + 1 : 0;
        assert (!wb_cyc)   // Gap cycle right after the 16th ack
        else
        begin
          $display("** Error %s gap: expected cyc 0, actual %b", cur_test, wb_cyc);
          errors++;
        end
        assert (sts_block == block_idx_t'(m_block))
        else
        begin
          $display("** Error %s sts_block: expected %0d, actual %0d", cur_test, m_block,
                   sts_block);
          errors++;
        end
      end
      else
      begin
        m_beat++;
      end
    end
  end

  task automatic apply_reset();
    aresetn <= 1'b0;
    s_tvalid <= 1'b0;
    for (int i = 0; i < 5; i++)
    begin
      @(posedge aclk);
      if (i > 0)   // Outputs show the reset state from the second edge on
      begin
        assert (!wb_cyc && !wb_stb && sts_block == '0 && s_tready)
        else
        begin
          $display("** Error %s reset: expected cyc/stb/sts 0 ready 1, actual %b/%b/%0d %b",
                   cur_test, wb_cyc, wb_stb, sts_block, s_tready);
          errors++;
        end
      end
    end
    aresetn <= 1'b1;
    exp_q.delete();
    blk_seq.delete();
    m_beat    = 0;
    m_block   = 0;
    n_written = 0;
    n_sent    = 0;
    @(posedge aclk);
  endtask

  // Sends n words, random valid unless steady is set
  task automatic send_words(input int n, input bit steady);
    int  sent;
    bit  acc;
    sent = 0;
    s_tvalid <= steady ? 1'b1 : 1'($urandom_range(0, 2) != 0);
    s_tdata  <= DATA_WIDTH'($urandom);
    while (sent < n)
    begin
      @(posedge aclk);
      acc = s_tvalid && s_tready;
      if (s_tvalid && !s_tready)
      begin
        bp_seen = 1'b1;
      end
      if (acc)
      begin
        exp_q.push_back(s_tdata);
        sent++;
        n_sent++;
      end
      if (sent >= n)
      begin
        s_tvalid <= 1'b0;
      end
      else if (acc || !s_tvalid)
      begin
        s_tvalid <= steady ? 1'b1 : 1'($urandom_range(0, 2) != 0);
        s_tdata  <= DATA_WIDTH'($urandom);
      end
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (n_written < n_sent && cycles < n_sent * 40)
    begin
      @(posedge aclk);
      cycles++;
    end
    assert (n_written == n_sent)
    else
    begin
      $display("%s: the DUT stopped writing with %0d of %0d words done", cur_test, n_written,
               n_sent);
      errors++;
    end
    repeat (10) @(posedge aclk);   // Catch any extra writes
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_errors)
    begin
      $display("Test %s: ok", cur_test);
    end
    else
    begin
      $display("Test %s: failed with %0d errors", cur_test, errors - test_errors);
      tests_failed++;
    end
    test_errors = errors;
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    assert (expected == actual)
    else
    begin
      $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  initial
  begin
    void'($urandom(34));
    aresetn    = 1'b0;
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    base_addr  = BASE;
    last_block = block_idx_t'(2);
    slow       = 1'b0;
    cyc_seen   = 1'b0;
    bp_seen    = 1'b0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;

    cur_test = "reset";
    apply_reset();
    repeat (3) @(posedge aclk);
    check_count("cyc after reset", 0, int'(wb_cyc));
    check_count("stb after reset", 0, int'(wb_stb));
    check_count("sts_block after reset", 0, int'(sts_block));
    check_count("ready after reset", 1, int'(s_tready));
    finish_test();

    cur_test = "threshold";
    apply_reset();
    cyc_seen = 1'b0;
    send_words(15, 1'b0);
    repeat (50) @(posedge aclk);
    check_count("cyc rises below one block", 0, int'(cyc_seen));
    send_words(1, 1'b0);
    wait_drain();
    check_count("words in block", 16, n_written);
    finish_test();

    cur_test = "wrap";
    apply_reset();
    send_words(80, 1'b0);
    wait_drain();
    check_count("blocks", 5, blk_seq.size());
    for (int i = 0; i < blk_seq.size(); i++)
    begin
      check_count($sformatf("block %0d index", i), i % 3, blk_seq[i]);
    end
    finish_test();

    cur_test = "backpressure";
    apply_reset();
    slow    = 1'b1;
    bp_seen = 1'b0;
    send_words(96, 1'b1);
    wait_drain();
    check_count("ready low seen", 1, int'(bp_seen));
    check_count("words left", 0, exp_q.size());
    slow = 1'b0;
    finish_test();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tb/wb_ram_model.sv
`timescale 1ns/1ps

module wb_ram_model
#(
  parameter int DATA_WIDTH = 32
)
(
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  slow,        // Force 3 wait states on every write

  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [31:0]           wb_adr,
  input  logic [DATA_WIDTH-1:0] wb_dat,
  output logic                  wb_ack,

  output logic                  log_valid,   // One cycle per completed write
  output logic [31:0]           log_addr,
  output logic [DATA_WIDTH-1:0] log_data
);

  logic [DATA_WIDTH-1:0] mem [1024];
  logic                  busy;
  int                    wait_cnt;

  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wb_ack    <= 1'b0;
      busy      <= 1'b0;
      wait_cnt  <= 0;
      log_valid <= 1'b0;
      log_addr  <= '0;
      log_data  <= '0;
    end
    else
    begin
      wb_ack    <= 1'b0;
      log_valid <= 1'b0;
      if (wb_cyc && wb_stb && wb_ack)
      begin
        // Write completes on this edge
        if (wb_we)
        begin
          mem[wb_adr[11:2]] <= wb_dat;
        end
        log_valid <= 1'b1;
        log_addr  <= wb_adr;
        log_data  <= wb_dat;
        busy      <= 1'b0;
      end
      else if (wb_cyc && wb_stb && !busy)
      begin
        busy     <= 1'b1;
        wait_cnt <= slow ? 3 : int'($urandom_range(0, 3));
      end
      else if (busy)
      begin
        if (wait_cnt == 0)
        begin
          wb_ack <= 1'b1;
        end
        else
        begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

// File: hdl/stream_ram_writer.sv
`timescale 1ns/1ps

module stream_ram_writer
  import ram_writer_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 64   // Power of two, at least one block
)
(
  input  logic                  aclk,
  input  logic                  aresetn,

  // Stream input
  input  logic [DATA_WIDTH-1:0] s_tdata,
  input  logic                  s_tvalid,
  output logic                  s_tready,

  // Configuration and status
  input  wb_addr_t              base_addr,
  input  block_idx_t            last_block,
  output block_idx_t            sts_block,    // Block currently being filled in memory

  // Wishbone classic master
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output wb_addr_t              wb_adr,
  output logic [DATA_WIDTH-1:0] wb_dat_o,
  input  logic                  wb_ack
);

  logic block_ready;
  logic block_last;
  logic pop;

  stream_fifo #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_stream_fifo (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_tdata     (s_tdata),
    .s_tvalid    (s_tvalid),
    .s_tready    (s_tready),
    .pop         (pop),
    .head_data   (wb_dat_o),   // Head word goes straight onto the bus
    .block_ready (block_ready)
  );

  write_address_counter #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_write_address_counter (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .pop        (pop),
    .base_addr  (base_addr),
    .last_block (last_block),
    .wb_adr     (wb_adr),
    .block_last (block_last),
    .sts_block  (sts_block)
  );

  block_write_fsm u_block_write_fsm (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .block_ready (block_ready),
    .block_last  (block_last),
    .wb_ack      (wb_ack),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .pop         (pop)
  );

endmodule

// File: hdl/block_write_fsm.sv
`timescale 1ns/1ps

module block_write_fsm
  import ram_writer_pkg::*;
(
  input  logic aclk,
  input  logic aresetn,

  input  logic block_ready,   // FIFO holds a full block
  input  logic block_last,    // Current beat is 15
  input  logic wb_ack,

  output logic wb_cyc,
  output logic wb_stb,
  output logic wb_we,
  output logic pop            // Accepted write, advances FIFO and counter
);

  wr_state_t state;
  wr_state_t state_next;
  logic      in_write;

  // Next state
  always_comb
  begin
    state_next = state;

    case (state)
      ST_IDLE:
      begin
        if (block_ready)
        begin
          state_next = ST_WRITE;
        end
      end

      ST_WRITE:
      begin
        if (wb_ack && block_last)
        begin
          state_next = ST_GAP;   // 16th write acknowledged
        end
      end

      ST_GAP:
      begin
        state_next = ST_IDLE;
      end

      default:
      begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      state <= state_next;
    end
  end

  // Bus strobes straight from the state register
  assign in_write = (state == ST_WRITE);
  assign wb_cyc   = in_write;
  assign wb_stb   = in_write;   // Next word is always queued, so no stb gaps
  assign wb_we    = in_write;

  assign pop = wb_stb & wb_ack;

  // Slave may only acknowledge a write that is in progress
  a_ack_in_write: assert property (
    @(posedge aclk) disable iff (!aresetn)
    wb_ack |-> (state == ST_WRITE)
  ) else $error("block_write_fsm: ack outside a write cycle");

endmodule

// File: hdl/write_address_counter.sv
`timescale 1ns/1ps

module write_address_counter
  import ram_writer_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)
(
  input  logic       aclk,
  input  logic       aresetn,

  input  logic       pop,          // One word written to memory
  input  wb_addr_t   base_addr,    // Start of the circular buffer
  input  block_idx_t last_block,   // Highest block index before wrap

  output wb_addr_t   wb_adr,
  output logic       block_last,   // Current word is the last of its block
  output block_idx_t sts_block
);

  // Byte address shift for one word
  localparam int BYTE_SHIFT = $clog2(DATA_WIDTH / 8);

  beat_idx_t  beat_q;
  block_idx_t block_q;
  wb_addr_t   word_offset;

  assign block_last = (beat_q == beat_idx_t'(BLOCK_BEATS - 1));

  // Block times 16 plus beat, as words
  assign word_offset = wb_addr_t'({block_q, beat_q});
  assign wb_adr      = base_addr + (word_offset << BYTE_SHIFT);
  assign sts_block   = block_q;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      beat_q  <= '0;
      block_q <= '0;
    end
    else if (pop)
    begin
      beat_q <= beat_q + beat_idx_t'(1);   // Rolls back to 0 after beat 15

      if (block_last)
      begin
        if (block_q < last_block)
        begin
          block_q <= block_q + block_idx_t'(1);
        end
        else
        begin
          block_q <= '0;   // Wrap to the start of the buffer
        end
      end
    end
  end

endmodule

// File: hdl/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo
  import ram_writer_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 64
)
(
  input  logic                  aclk,
  input  logic                  aresetn,

  input  logic [DATA_WIDTH-1:0] s_tdata,
  input  logic                  s_tvalid,
  output logic                  s_tready,

  input  logic                  pop,          // Word consumed by the bus side
  output logic [DATA_WIDTH-1:0] head_data,    // Oldest word, valid while not empty
  output logic                  block_ready   // At least one full block queued
);

  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

  typedef logic [PTR_WIDTH-1:0] ptr_t;
  typedef logic [PTR_WIDTH:0]   count_t;   // One extra bit to hold FIFO_DEPTH

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;
  logic   full;
  logic   push;

  assign full        = (count == count_t'(FIFO_DEPTH));
  assign s_tready    = ~full;                 // Back-pressure toward the source
  assign push        = s_tvalid & s_tready;
  assign head_data   = mem[rd_ptr];           // Fall-through read of the head
  assign block_ready = (count >= count_t'(BLOCK_BEATS));

  // Storage array
  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= s_tdata;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + ptr_t'(1);   // Wraps, depth is a power of two
      end

      if (pop)
      begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end

      case ({push, pop})
        2'b10:
        begin
          count <= count + count_t'(1);
        end
        2'b01:
        begin
          count <= count - count_t'(1);
        end
        default:
        begin
          count <= count;   // Idle or push and pop together
        end
      endcase
    end
  end

  // The bus side may only consume words that are present
  a_no_pop_when_empty: assert property (
    @(posedge aclk) disable iff (!aresetn)
    pop |-> (count != '0)
  ) else $error("stream_fifo: pop while empty");

endmodule

// File: hdl/ram_writer_pkg.sv
package ram_writer_pkg;

  // Words per block, one block is moved as 16 single writes
  localparam int BLOCK_BEATS = 16;

  localparam int WB_ADDR_WIDTH   = 32;                    // Byte address on the bus
  localparam int BEAT_WIDTH      = $clog2(BLOCK_BEATS);   // Word index within a block
  localparam int BLOCK_IDX_WIDTH = 12;                    // Up to 4096 blocks in the ring

  // Byte address driven on wb_adr
  typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;

  // Position of the current word inside its block
  typedef logic [BEAT_WIDTH-1:0] beat_idx_t;

  // Block index in the circular buffer, also the software status
  typedef logic [BLOCK_IDX_WIDTH-1:0] block_idx_t;

  // Write controller states
  typedef enum logic [1:0]
  {
    ST_IDLE  = 2'd0,  // Waiting for a full block
    ST_WRITE = 2'd1,  // Bus cycle in progress
    ST_GAP   = 2'd2   // One idle cycle between blocks
  } wr_state_t;

endpackage
